//--- include/video_defines.svh
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Pixel column and line counters
`define COORD_W 12

// Wishbone word address
`define WB_ADR_W 4

// Register map, word addresses
`define REG_CTRL      4'd0
`define REG_THRESH    4'd1
`define REG_BOX_X     4'd2
`define REG_BOX_Y     4'd3
`define REG_BOX_COLOR 4'd4

// Read only, writes are acked and dropped
`define REG_FRAMES    4'd5

`endif

//--- hw/video_pkg.sv
`include "video_defines.svh"

package video_pkg;

   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } rgb_t;

   // One pixel clock worth of video
   typedef struct packed {
      logic hs;
      logic vs;
      logic de;
      rgb_t rgb;
   } pix_t;

   typedef struct packed {
      logic                 cyc;
      logic                 stb;
      logic                 we;
      logic [`WB_ADR_W-1:0] adr;
      logic [31:0]          dat;
      logic [3:0]           sel;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic [2:0]          mode;
      logic                ovl_en;
      logic [7:0]          thresh;
      logic [`COORD_W-1:0] box_x0;
      logic [`COORD_W-1:0] box_x1;
      logic [`COORD_W-1:0] box_y0;
      logic [`COORD_W-1:0] box_y1;
      rgb_t                box_color;
   } vid_cfg_t;

endpackage

//--- hw/video_regs.sv
`timescale 1ns/1ps
`include "video_defines.svh"

module video_regs (
   input  logic                vin_clk,
   input  logic                reset_i,
   input  video_pkg::wb_req_t  wb_req_i,
   input  logic [31:0]         frames_i,
   output video_pkg::wb_rsp_t  wb_rsp_o,
   output video_pkg::vid_cfg_t cfg_o
);

   localparam int PAD_W = 16 - `COORD_W;

   video_pkg::vid_cfg_t cfg_q;
   logic                ack_q;
   logic [31:0]         rdat_q;
   logic                access;
   logic [31:0]         cur_word;
   logic [31:0]         byte_mask;
   logic [31:0]         new_word;

   // New cycle seen, not yet acked
   assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

   // Current contents of the addressed register
   always_comb begin
      case (wb_req_i.adr)
         `REG_CTRL:
            cur_word = {27'd0, cfg_q.ovl_en, 1'b0, cfg_q.mode};
         `REG_THRESH:
            cur_word = {24'd0, cfg_q.thresh};
         `REG_BOX_X:
            cur_word = {{PAD_W{1'b0}}, cfg_q.box_x1, {PAD_W{1'b0}}, cfg_q.box_x0};
         `REG_BOX_Y:
            cur_word = {{PAD_W{1'b0}}, cfg_q.box_y1, {PAD_W{1'b0}}, cfg_q.box_y0};
         `REG_BOX_COLOR:
            cur_word = {8'd0, cfg_q.box_color};
         `REG_FRAMES:
            cur_word = frames_i;
         default:
            cur_word = 32'd0;
      endcase
   end

   assign byte_mask = {{8{wb_req_i.sel[3]}}, {8{wb_req_i.sel[2]}},
                       {8{wb_req_i.sel[1]}}, {8{wb_req_i.sel[0]}}};

   // Merge selected bytes into the old value
   assign new_word = (cur_word & ~byte_mask) | (wb_req_i.dat & byte_mask);

   always_ff @(posedge vin_clk) begin
      if (reset_i) begin
         ack_q        <= 1'b0;
         cfg_q        <= '0;
         cfg_q.thresh <= 8'd128;
      end else begin
         ack_q <= access;
         if (access && wb_req_i.we) begin
            case (wb_req_i.adr)
               `REG_CTRL: begin
                  cfg_q.mode   <= new_word[2:0];
                  cfg_q.ovl_en <= new_word[4];
               end
               `REG_THRESH:
                  cfg_q.thresh <= new_word[7:0];
               `REG_BOX_X: begin
                  cfg_q.box_x0 <= new_word[`COORD_W-1:0];
                  cfg_q.box_x1 <= new_word[16+`COORD_W-1:16];
               end
               `REG_BOX_Y: begin
                  cfg_q.box_y0 <= new_word[`COORD_W-1:0];
                  cfg_q.box_y1 <= new_word[16+`COORD_W-1:16];
               end
               `REG_BOX_COLOR:
                  cfg_q.box_color <= new_word[23:0];
               default: ;
            endcase
         end
      end
   end

   // Read data lines up with ack
   always_ff @(posedge vin_clk) begin
      if (access) begin
         rdat_q <= cur_word;
      end
   end

   assign wb_rsp_o = '{ack: ack_q, dat: rdat_q};
   assign cfg_o    = cfg_q;

endmodule

//--- hw/raster_tracker.sv
`timescale 1ns/1ps
`include "video_defines.svh"

module raster_tracker (
   input  logic                vin_clk,
   input  logic                reset_i,
   input  video_pkg::pix_t     pix_i,
   output logic [`COORD_W-1:0] x_o,
   output logic [`COORD_W-1:0] y_o,
   output logic [31:0]         frames_o
);

   logic                de_q;
   logic                vs_q;
   logic [`COORD_W-1:0] col_q;
   logic [`COORD_W-1:0] line_q;
   logic [31:0]         frame_q;
   logic                de_fall;
   logic                vs_rise;

   assign de_fall = de_q & ~pix_i.de;
   assign vs_rise = pix_i.vs & ~vs_q;

   always_ff @(posedge vin_clk) begin
      if (reset_i) begin
         de_q    <= 1'b0;
         vs_q    <= 1'b0;
         col_q   <= '0;
         line_q  <= '0;
         frame_q <= 32'd0;
      end else begin
         de_q <= pix_i.de;
         vs_q <= pix_i.vs;
         if (pix_i.de) begin
            col_q <= col_q + 1'b1;
         end else if (de_fall) begin
            col_q <= '0;
         end
         // Frame start wins over end of line
         if (vs_rise) begin
            line_q <= '0;
         end else if (de_fall) begin
            line_q <= line_q + 1'b1;
         end
         if (vs_rise) begin
            frame_q <= frame_q + 32'd1;
         end
      end
   end

   // Counters already hold the position of the pixel on pix_i
   assign x_o      = col_q;
   assign y_o      = line_q;
   assign frames_o = frame_q;

endmodule

//--- hw/pixel_effect.sv
`timescale 1ns/1ps

module pixel_effect (
   input  logic                vin_clk,
   input  logic                reset_i,
   input  video_pkg::vid_cfg_t cfg_i,
   input  video_pkg::pix_t     pix_i,
   output video_pkg::pix_t     pix_o
);

   video_pkg::pix_t s1_pix;
   video_pkg::pix_t s2_pix;
   video_pkg::rgb_t fx_rgb;
   logic [7:0]      s1_luma;
   logic [9:0]      luma_sum;

   // r + 2g + b, fits in 10 bits
   assign luma_sum = {2'b00, pix_i.rgb.r}
                   + {1'b0, pix_i.rgb.g, 1'b0}
                   + {2'b00, pix_i.rgb.b};

   always_comb begin
      case (cfg_i.mode)
         3'd1: begin
            fx_rgb = ~s1_pix.rgb;
         end
         3'd2: begin
            fx_rgb.r = s1_luma;
            fx_rgb.g = s1_luma;
            fx_rgb.b = s1_luma;
         end
         3'd3: begin
            fx_rgb = (s1_luma >= cfg_i.thresh) ? 24'hffffff : 24'h000000;
         end
         3'd4: begin
            fx_rgb.r = s1_pix.rgb.g;
            fx_rgb.g = s1_pix.rgb.b;
            fx_rgb.b = s1_pix.rgb.r;
         end
         default: begin
            fx_rgb = s1_pix.rgb;
         end
      endcase
   end

   always_ff @(posedge vin_clk) begin
      // Stage 1, pixel and its luma
      s1_pix  <= pix_i;
      s1_luma <= luma_sum[9:2];
      // Stage 2, effect applied, syncs follow
      s2_pix.hs  <= s1_pix.hs;
      s2_pix.vs  <= s1_pix.vs;
      s2_pix.de  <= s1_pix.de;
      s2_pix.rgb <= fx_rgb;
      if (reset_i) begin
         s1_pix.hs <= 1'b0;
         s1_pix.vs <= 1'b0;
         s1_pix.de <= 1'b0;
         s2_pix.hs <= 1'b0;
         s2_pix.vs <= 1'b0;
         s2_pix.de <= 1'b0;
      end
   end

   assign pix_o = s2_pix;

endmodule

//--- hw/overlay_box.sv
`timescale 1ns/1ps
`include "video_defines.svh"

module overlay_box (
   input  logic                vin_clk,
   input  logic                reset_i,
   input  video_pkg::vid_cfg_t cfg_i,
   input  video_pkg::pix_t     pix_i,
   input  logic [`COORD_W-1:0] x_i,
   input  logic [`COORD_W-1:0] y_i,
   output video_pkg::pix_t     pix_o
);

   video_pkg::pix_t pix_q;
   logic            in_x;
   logic            in_y;
   logic            on_col;
   logic            on_row;
   logic            hit;

   assign in_x = (x_i >= cfg_i.box_x0) && (x_i <= cfg_i.box_x1);
   assign in_y = (y_i >= cfg_i.box_y0) && (y_i <= cfg_i.box_y1);

   // Left and right edges, then top and bottom
   assign on_col = ((x_i == cfg_i.box_x0) || (x_i == cfg_i.box_x1)) && in_y;
   assign on_row = ((y_i == cfg_i.box_y0) || (y_i == cfg_i.box_y1)) && in_x;

   assign hit = cfg_i.ovl_en & pix_i.de & (on_col | on_row);

   always_ff @(posedge vin_clk) begin
      pix_q <= pix_i;
      if (hit) begin
         pix_q.rgb <= cfg_i.box_color;
      end
      if (reset_i) begin
         pix_q.hs <= 1'b0;
         pix_q.vs <= 1'b0;
         pix_q.de <= 1'b0;
      end
   end

   assign pix_o = pix_q;

endmodule

//--- hw/video_top.sv
`timescale 1ns/1ps
`include "video_defines.svh"

module video_top (
   input  logic               vin_clk,
   input  logic               reset_i,
   input  video_pkg::pix_t    pix_i,
   input  video_pkg::wb_req_t wb_req_i,
   output video_pkg::pix_t    pix_o,
   output video_pkg::wb_rsp_t wb_rsp_o
);

   video_pkg::vid_cfg_t cfg;
   video_pkg::pix_t     fx_pix;
   logic [31:0]         frames;
   logic [`COORD_W-1:0] x;
   logic [`COORD_W-1:0] y;

   video_regs i_video_regs (
      .vin_clk  (vin_clk),
      .reset_i  (reset_i),
      .wb_req_i (wb_req_i),
      .frames_i (frames),
      .wb_rsp_o (wb_rsp_o),
      .cfg_o    (cfg)
   );

   // Two cycles
   pixel_effect i_pixel_effect (
      .vin_clk (vin_clk),
      .reset_i (reset_i),
      .cfg_i   (cfg),
      .pix_i   (pix_i),
      .pix_o   (fx_pix)
   );

   // Position of the pixel leaving the effect stage
   raster_tracker i_raster_tracker (
      .vin_clk  (vin_clk),
      .reset_i  (reset_i),
      .pix_i    (fx_pix),
      .x_o      (x),
      .y_o      (y),
      .frames_o (frames)
   );

   // One cycle
   overlay_box i_overlay_box (
      .vin_clk (vin_clk),
      .reset_i (reset_i),
      .cfg_i   (cfg),
      .pix_i   (fx_pix),
      .x_i     (x),
      .y_i     (y),
      .pix_o   (pix_o)
   );

endmodule

//--- test/video_properties.sv
`timescale 1ns/1ps

module video_properties (
   input logic               vin_clk,
   input logic               reset_i,
   input video_pkg::pix_t    pix_i,
   input video_pkg::pix_t    pix_o,
   input video_pkg::wb_req_t wb_req_i,
   input video_pkg::wb_rsp_t wb_rsp_o
);

   int unsigned fail_cnt = 0;

   ack_needs_request: assert property (@(posedge vin_clk) disable iff (reset_i)
      wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb))
      else begin
         fail_cnt++;
         $error("ack raised without cyc and stb");
      end

   ack_one_cycle: assert property (@(posedge vin_clk) disable iff (reset_i)
      wb_rsp_o.ack |=> !wb_rsp_o.ack)
      else begin
         fail_cnt++;
         $error("ack held high for two cycles");
      end

   // Three register stages between pix_i and pix_o
   de_latency: assert property (@(posedge vin_clk) disable iff (reset_i)
      pix_o.de == $past(pix_i.de, 3))
      else begin
         fail_cnt++;
         $error("pix_o.de does not follow pix_i.de by 3 cycles");
      end

   syncs_low_in_reset: assert property (@(posedge vin_clk)
      reset_i |=> (!pix_o.hs && !pix_o.vs && !pix_o.de))
      else begin
         fail_cnt++;
         $error("pix_o syncs not low during reset");
      end

endmodule

bind video_top video_properties u_video_properties (
   .vin_clk  (vin_clk),
   .reset_i  (reset_i),
   .pix_i    (pix_i),
   .pix_o    (pix_o),
   .wb_req_i (wb_req_i),
   .wb_rsp_o (wb_rsp_o)
);

//--- test/video_tb.sv
`timescale 1ns/1ps
`include "video_defines.svh"

module video_tb;

   localparam int ACTIVE       = 8;
   localparam int BLANK        = 4;
   localparam int LINES        = 4;
   localparam int FRAME_CYCLES = 4 + LINES * (ACTIVE + BLANK);
   localparam int NUM_TESTS    = 6;
   localparam int WATCHDOG     = NUM_TESTS * FRAME_CYCLES * 4 + 1000;

   typedef struct packed {
      logic [31:0]     due;
      video_pkg::pix_t pix;
   } exp_t;

   logic                vin_clk;
   logic                reset_i;
   video_pkg::pix_t     pix_i;
   video_pkg::wb_req_t  wb_req_i;
   video_pkg::pix_t     pix_o;
   video_pkg::wb_rsp_t  wb_rsp_o;
   video_pkg::vid_cfg_t model_cfg;
   logic [31:0]         lcg_state;
   logic [31:0]         cyc_cnt;
   int                  frames_sent;
   exp_t                exp_q[$];
   exp_t                mon_exp;

   video_top UUT (
      .vin_clk  (vin_clk),
      .reset_i  (reset_i),
      .pix_i    (pix_i),
      .wb_req_i (wb_req_i),
      .pix_o    (pix_o),
      .wb_rsp_o (wb_rsp_o)
   );

   always #50 vin_clk = ~vin_clk;

   always @(posedge vin_clk) begin
      cyc_cnt <= cyc_cnt + 32'd1;
   end

   task automatic fail_run();
      $display("RESULT: FAIL");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("ERR %s got 0x%08h expected 0x%08h", name, got, expected);
         fail_run();
      end
   endtask

   function logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic wb_access(input logic we, input logic [`WB_ADR_W-1:0] adr,
                            input logic [31:0] dat, input logic [3:0] sel,
                            output logic [31:0] rdat);
      video_pkg::wb_req_t req;
      int                 waited;
      req     = '0;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      req.we  = we;
      req.adr = adr;
      req.dat = dat;
      req.sel = sel;
      waited  = 0;
      @(posedge vin_clk);
      wb_req_i <= req;
      @(negedge vin_clk);
      while (!wb_rsp_o.ack && waited < 8) begin
         waited++;
         @(negedge vin_clk);
      end
      if (!wb_rsp_o.ack) begin
         $display("Bus access to address %0d was never acknowledged", adr);
         fail_run();
      end else begin
         rdat = wb_rsp_o.dat;
         @(posedge vin_clk);
         wb_req_i <= '0;
      end
   endtask

   task automatic wb_write(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel);
      logic [31:0] unused;
      wb_access(1'b1, adr, dat, sel, unused);
   endtask

   task automatic reg_expect(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] expected);
      logic [31:0] rdat;
      wb_access(1'b0, adr, 32'd0, 4'hf, rdat);
      check_value($sformatf("wb_rsp_o.dat at address %0d", adr), rdat, expected);
   endtask

   function automatic video_pkg::vid_cfg_t base_cfg(input logic [2:0] mode);
      video_pkg::vid_cfg_t cfg;
      cfg        = '0;
      cfg.mode   = mode;
      cfg.thresh = 8'd128;
      return cfg;
   endfunction

   task automatic apply_cfg(input video_pkg::vid_cfg_t cfg);
      logic [15-`COORD_W:0] pad;
      pad = '0;
      wb_write(`REG_CTRL, {27'd0, cfg.ovl_en, 1'b0, cfg.mode}, 4'hf);
      wb_write(`REG_THRESH, {24'd0, cfg.thresh}, 4'hf);
      wb_write(`REG_BOX_X, {pad, cfg.box_x1, pad, cfg.box_x0}, 4'hf);
      wb_write(`REG_BOX_Y, {pad, cfg.box_y1, pad, cfg.box_y0}, 4'hf);
      wb_write(`REG_BOX_COLOR, {8'd0, cfg.box_color}, 4'hf);
      model_cfg = cfg;
   endtask

   function automatic logic on_outline(input int x, input int y);
      logic in_x;
      logic in_y;
      in_x = (x >= model_cfg.box_x0) && (x <= model_cfg.box_x1);
      in_y = (y >= model_cfg.box_y0) && (y <= model_cfg.box_y1);
      return ((x == model_cfg.box_x0 || x == model_cfg.box_x1) && in_y)
          || ((y == model_cfg.box_y0 || y == model_cfg.box_y1) && in_x);
   endfunction

   function automatic video_pkg::pix_t expected_pixel(input video_pkg::pix_t pix,
                                                     input int x, input int y);
      video_pkg::pix_t res;
      int              luma;
      res  = pix;
      luma = (int'(pix.rgb.r) + 2 * int'(pix.rgb.g) + int'(pix.rgb.b)) / 4;
      case (model_cfg.mode)
         3'd1: res.rgb = ~pix.rgb;
         3'd2: res.rgb = {3{luma[7:0]}};
         3'd3: res.rgb = (luma >= model_cfg.thresh) ? 24'hffffff : 24'h000000;
         3'd4: res.rgb = {pix.rgb.g, pix.rgb.b, pix.rgb.r};
         default: res.rgb = pix.rgb;
      endcase
      if (model_cfg.ovl_en && pix.de && on_outline(x, y)) begin
         res.rgb = model_cfg.box_color;
      end
      return res;
   endfunction

   // Pattern 1 puts lumas just below, at and above thresh in front of each line
   function automatic video_pkg::rgb_t make_rgb(input int pattern, input int col);
      logic [31:0]     rnd;
      logic [7:0]      t;
      video_pkg::rgb_t c;
      rnd = next_random();
      c   = rnd[31:8];
      t   = model_cfg.thresh;
      if (pattern == 1) begin
         case (col)
            0: c = {t - 8'd1, t - 8'd1, t - 8'd1};
            1: c = {t, t, t};
            2: c = {t + 8'd1, t + 8'd1, t + 8'd1};
            3: c = {t + 8'd2, t, t - 8'd2};
            4: c = {t + 8'd3, t, t - 8'd2};
            5: c = {t - 8'd1, t, t - 8'd2};
            default: ;
         endcase
      end
      return c;
   endfunction

   task automatic drive_pixel(input video_pkg::pix_t pix, input int x, input int y);
      exp_t e;
      @(posedge vin_clk);
      pix_i <= pix;
      // Counter reads one behind here, so the output is due 4 counts on
      e.due = cyc_cnt + 32'd4;
      e.pix = expected_pixel(pix, x, y);
      exp_q.push_back(e);
   endtask

   task automatic send_frame(input int pattern);
      video_pkg::pix_t pix;
      for (int i = 0; i < 4; i++) begin
         pix    = '0;
         pix.vs = (i < 2);
         drive_pixel(pix, 0, 0);
      end
      for (int line = 0; line < LINES; line++) begin
         for (int col = 0; col < ACTIVE; col++) begin
            pix     = '0;
            pix.de  = 1'b1;
            pix.rgb = make_rgb(pattern, col);
            drive_pixel(pix, col, line);
         end
         for (int b = 0; b < BLANK; b++) begin
            pix    = '0;
            pix.hs = (b == 1 || b == 2);
            drive_pixel(pix, 0, 0);
         end
      end
      frames_sent++;
      while (exp_q.size() > 0) begin
         @(negedge vin_clk);
      end
   endtask

   task automatic register_access();
      reg_expect(`REG_CTRL, 32'h0);
      reg_expect(`REG_THRESH, 32'h80);
      reg_expect(`REG_BOX_X, 32'h0);
      reg_expect(`REG_BOX_Y, 32'h0);
      reg_expect(`REG_BOX_COLOR, 32'h0);
      reg_expect(`REG_FRAMES, 32'h0);
      wb_write(`REG_CTRL, 32'h0000_0013, 4'hf);
      reg_expect(`REG_CTRL, 32'h0000_0013);
      wb_write(`REG_CTRL, 32'hffff_ffff, 4'hf);
      reg_expect(`REG_CTRL, 32'h0000_0017);
      wb_write(`REG_THRESH, 32'hffff_ff3c, 4'hf);
      reg_expect(`REG_THRESH, 32'h0000_003c);
      wb_write(`REG_BOX_X, 32'h0abc_0123, 4'hf);
      reg_expect(`REG_BOX_X, 32'h0abc_0123);
      wb_write(`REG_BOX_Y, 32'hffff_ffff, 4'hf);
      reg_expect(`REG_BOX_Y, 32'h0fff_0fff);
      wb_write(`REG_BOX_COLOR, 32'h1122_3344, 4'hf);
      reg_expect(`REG_BOX_COLOR, 32'h0022_3344);
      // Single byte lanes
      wb_write(`REG_BOX_COLOR, 32'haabb_ccdd, 4'b0010);
      reg_expect(`REG_BOX_COLOR, 32'h0022_cc44);
      wb_write(`REG_BOX_X, 32'h0055_0000, 4'b0100);
      reg_expect(`REG_BOX_X, 32'h0a55_0123);
      wb_write(`REG_BOX_Y, 32'h0000_0000, 4'b0001);
      reg_expect(`REG_BOX_Y, 32'h0fff_0f00);
      wb_write(`REG_FRAMES, 32'h1234_5678, 4'hf);
      reg_expect(`REG_FRAMES, 32'h0);
      wb_write(4'd6, 32'hdead_beef, 4'hf);
      reg_expect(4'd6, 32'h0);
      reg_expect(4'd15, 32'h0);
   endtask

   task automatic pass_mode_timing();
      apply_cfg(base_cfg(3'd0));
      send_frame(0);
   endtask

   task automatic invert_and_rotate();
      apply_cfg(base_cfg(3'd1));
      send_frame(0);
      apply_cfg(base_cfg(3'd4));
      send_frame(0);
      for (int m = 5; m < 8; m++) begin
         apply_cfg(base_cfg(3'(m)));
         send_frame(0);
      end
   endtask

   task automatic gray_and_threshold();
      video_pkg::vid_cfg_t cfg;
      apply_cfg(base_cfg(3'd2));
      send_frame(0);
      cfg        = base_cfg(3'd3);
      cfg.thresh = 8'd100;
      apply_cfg(cfg);
      send_frame(1);
      cfg.thresh = 8'd200;
      apply_cfg(cfg);
      send_frame(1);
   endtask

   task automatic box_overlay();
      video_pkg::vid_cfg_t cfg;
      cfg           = base_cfg(3'd1);
      cfg.ovl_en    = 1'b1;
      cfg.box_x0    = 1;
      cfg.box_x1    = 5;
      cfg.box_y0    = 1;
      cfg.box_y1    = 2;
      cfg.box_color = 24'h20c040;
      apply_cfg(cfg);
      send_frame(0);
      cfg.mode = 3'd0;
      apply_cfg(cfg);
      send_frame(0);
      cfg.ovl_en = 1'b0;
      apply_cfg(cfg);
      send_frame(0);
   endtask

   task automatic frame_count_readback();
      reg_expect(`REG_FRAMES, frames_sent);
      send_frame(0);
      send_frame(0);
      reg_expect(`REG_FRAMES, frames_sent);
   endtask

   always @(negedge vin_clk) begin
      if (!reset_i) begin
         if (exp_q.size() > 0 && exp_q[0].due == cyc_cnt) begin
            mon_exp = exp_q.pop_front();
            check_value("pix_o.{hs,vs,de}", {29'd0, pix_o.hs, pix_o.vs, pix_o.de},
                        {29'd0, mon_exp.pix.hs, mon_exp.pix.vs, mon_exp.pix.de});
            if (mon_exp.pix.de) begin
               check_value("pix_o.rgb", {8'd0, pix_o.rgb}, {8'd0, mon_exp.pix.rgb});
            end
         end else begin
            check_value("pix_o.{hs,vs,de}", {29'd0, pix_o.hs, pix_o.vs, pix_o.de}, 32'd0);
         end
      end
   end

   // Bound assertions on the DUT
   always @(negedge vin_clk) begin
      if (UUT.u_video_properties.fail_cnt != 0) begin
         $display("A bound assertion on the DUT failed");
         fail_run();
      end
   end

   initial begin
      repeat (WATCHDOG) @(posedge vin_clk);
      $display("Timeout, tests still running after %0d clock cycles", WATCHDOG);
      fail_run();
   end

   initial begin
      vin_clk     = 1'b0;
      reset_i     = 1'b1;
      pix_i       = '0;
      wb_req_i    = '0;
      lcg_state   = 32'd26962;
      cyc_cnt     = 32'd0;
      frames_sent = 0;
      model_cfg   = '0;
      repeat (16) @(posedge vin_clk);
      reset_i <= 1'b0;
      register_access();
      pass_mode_timing();
      invert_and_rotate();
      gray_and_threshold();
      box_overlay();
      frame_count_readback();
      @(negedge vin_clk);
      if (exp_q.size() == 0 && UUT.u_video_properties.fail_cnt == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         $display("Run ended with unchecked pixels or a failed assertion");
         fail_run();
      end
   end

endmodule

//--- tb.f
+incdir+include
hw/video_pkg.sv
hw/video_regs.sv
hw/raster_tracker.sv
hw/pixel_effect.sv
hw/overlay_box.sv
hw/video_top.sv
test/video_properties.sv
test/video_tb.sv

//--- Bender.yml
package:
  name: video_fx

sources:
  - include_dirs:
      - include
    files:
      - hw/video_pkg.sv
      - hw/video_regs.sv
      - hw/raster_tracker.sv
      - hw/pixel_effect.sv
      - hw/overlay_box.sv
      - hw/video_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/video_properties.sv
      - test/video_tb.sv
